/* hdl/vgaTimingPkg.sv */
package vgaTimingPkg;

	// Scan positions and the compare values they are matched against
	typedef logic [10:0] hCount;
	typedef logic [9:0] vCount;

	// Pixel size in clocks or lines, minus one
	typedef logic [3:0] stretchCount;

	// Five 6-bit pixels are packed into each memory word
	typedef logic [2:0] subPixelIndex;
	localparam subPixelIndex maxSubPixel = 3'd4;

	typedef logic [31:0] pixelWord;
	typedef logic [5:0] colourPixel;
	typedef logic [1:0] colourChannel;

	// 800 x 600 at 60 Hz with a 40 MHz pixel clock
	localparam hCount defaultHVisible = 11'd799;
	localparam hCount defaultHFrontPorch = 11'd839;
	localparam hCount defaultHSync = 11'd967;
	localparam hCount defaultHWholeLine = 11'd1055;
	localparam vCount defaultVVisible = 10'd599;
	localparam vCount defaultVFrontPorch = 10'd600;
	localparam vCount defaultVSync = 10'd604;
	localparam vCount defaultVWholeLine = 10'd627;

	localparam stretchCount defaultPixelSize = 4'd10;

	// Raw mode address fields, 128 rows by 16 words of 5 pixels
	localparam int rowBits = 7;
	localparam int columnBits = 4;

endpackage

/* hdl/vgaBusPkg.sv */
package vgaBusPkg;

	typedef logic [23:0] busAddr;
	typedef logic [31:0] busWord;
	typedef logic [11:0] regOffset;

	// Upper twelve address bits that select this block
	localparam logic [11:0] configBlock = 12'h010;

	// Register map
	localparam regOffset hVisibleReg = 12'h000;
	localparam regOffset hFrontPorchReg = 12'h004;
	localparam regOffset hSyncReg = 12'h008;
	localparam regOffset hWholeLineReg = 12'h00C;
	localparam regOffset vVisibleReg = 12'h010;
	localparam regOffset vFrontPorchReg = 12'h014;
	localparam regOffset vSyncReg = 12'h018;
	localparam regOffset vWholeLineReg = 12'h01C;

	// Bits 3:0 horizontal size, 7:4 vertical size, 9:8 mode
	localparam regOffset configReg = 12'h020;

	// Only bit 8 of the mode field is decoded
	typedef enum logic {
		drawRaw = 1'b0,
		drawTight = 1'b1
	} drawMode;

endpackage

/* hdl/vgaConfigRegs.sv */
`timescale 1ns/1ps

module vgaConfigRegs import vgaTimingPkg::*, vgaBusPkg::*; (
	input logic vga_clk,
	input logic rstN,

	input logic busWe,
	input logic busOe,
	input busAddr busAddress,
	input busWord busDataWrite,
	output busWord busDataRead,
	output logic requestOutput,

	output hCount hVisible,
	output hCount hFrontPorch,
	output hCount hSync,
	output hCount hWholeLine,
	output vCount vVisible,
	output vCount vFrontPorch,
	output vCount vSync,
	output vCount vWholeLine,

	output stretchCount hPixelSize,
	output stretchCount vPixelSize,
	output drawMode mode
);

	logic blockHit;
	regOffset offset;
	logic mapped;
	logic regHit;
	busWord readValue;

	assign blockHit = busAddress[23:12] == configBlock;
	assign offset = busAddress[11:0];
	assign regHit = blockHit && mapped;

	// Offset decode and read mux
	always_comb begin
		mapped = 1'b1;
		readValue = '0;
		case (offset)
			hVisibleReg: readValue = busWord'(hVisible);
			hFrontPorchReg: readValue = busWord'(hFrontPorch);
			hSyncReg: readValue = busWord'(hSync);
			hWholeLineReg: readValue = busWord'(hWholeLine);
			vVisibleReg: readValue = busWord'(vVisible);
			vFrontPorchReg: readValue = busWord'(vFrontPorch);
			vSyncReg: readValue = busWord'(vSync);
			vWholeLineReg: readValue = busWord'(vWholeLine);
			configReg: readValue = busWord'({mode, vPixelSize, hPixelSize});
			default: mapped = 1'b0;
		endcase
	end

	// Full word writes, bits above each register width are dropped
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			hVisible <= defaultHVisible;
			hFrontPorch <= defaultHFrontPorch;
			hSync <= defaultHSync;
			hWholeLine <= defaultHWholeLine;
			vVisible <= defaultVVisible;
			vFrontPorch <= defaultVFrontPorch;
			vSync <= defaultVSync;
			vWholeLine <= defaultVWholeLine;
			hPixelSize <= defaultPixelSize;
			vPixelSize <= defaultPixelSize;
			mode <= drawRaw;
		end else if (busWe && regHit) begin
			case (offset)
				hVisibleReg: hVisible <= busDataWrite[10:0];
				hFrontPorchReg: hFrontPorch <= busDataWrite[10:0];
				hSyncReg: hSync <= busDataWrite[10:0];
				hWholeLineReg: hWholeLine <= busDataWrite[10:0];
				vVisibleReg: vVisible <= busDataWrite[9:0];
				vFrontPorchReg: vFrontPorch <= busDataWrite[9:0];
				vSyncReg: vSync <= busDataWrite[9:0];
				vWholeLineReg: vWholeLine <= busDataWrite[9:0];
				configReg: begin
					hPixelSize <= busDataWrite[3:0];
					vPixelSize <= busDataWrite[7:4];
					mode <= drawMode'(busDataWrite[8]);
				end
				default: ;
			endcase
		end
	end

	// Read data follows the access by one cycle and is zero otherwise
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			requestOutput <= 1'b0;
			busDataRead <= '0;
		end else begin
			requestOutput <= busOe && regHit;
			busDataRead <= (busOe && regHit) ? readValue : '0;
		end
	end

endmodule

/* hdl/vgaSyncTiming.sv */
`timescale 1ns/1ps

module vgaSyncTiming import vgaTimingPkg::*; (
	input logic vga_clk,
	input logic rstN,

	input hCount hVisible,
	input hCount hFrontPorch,
	input hCount hSync,
	input hCount hWholeLine,
	input vCount vVisible,
	input vCount vFrontPorch,
	input vCount vSync,
	input vCount vWholeLine,

	output logic hVisibleArea,
	output logic vVisibleArea,
	output logic lineEnd,
	output logic vgaHsync,
	output logic vgaVsync
);

	hCount hCounter;
	vCount vCounter;

	logic hVisibleEnd;
	logic hFrontPorchEnd;
	logic hSyncEnd;
	logic vVisibleEnd;
	logic vFrontPorchEnd;
	logic vSyncEnd;
	logic frameEnd;

	assign hVisibleEnd = hCounter == hVisible;
	assign hFrontPorchEnd = hCounter == hFrontPorch;
	assign hSyncEnd = hCounter == hSync;
	assign lineEnd = hCounter == hWholeLine;

	assign vVisibleEnd = vCounter == vVisible;
	assign vFrontPorchEnd = vCounter == vFrontPorch;
	assign vSyncEnd = vCounter == vSync;
	assign frameEnd = vCounter == vWholeLine;

	// Horizontal position steps every clock
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			hCounter <= '0;
			hVisibleArea <= 1'b1;
			vgaHsync <= 1'b1;
		end else begin
			if (lineEnd)
				hCounter <= '0;
			else
				hCounter <= hCounter + 1'b1;

			if (hVisibleEnd)
				hVisibleArea <= 1'b0;
			else if (lineEnd)
				hVisibleArea <= 1'b1;

			// Sync is active low
			if (hFrontPorchEnd)
				vgaHsync <= 1'b0;
			else if (hSyncEnd)
				vgaHsync <= 1'b1;
		end
	end

	// Vertical position steps once per line
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			vCounter <= '0;
			vVisibleArea <= 1'b1;
			vgaVsync <= 1'b1;
		end else if (lineEnd) begin
			if (frameEnd)
				vCounter <= '0;
			else
				vCounter <= vCounter + 1'b1;

			if (vVisibleEnd)
				vVisibleArea <= 1'b0;
			else if (frameEnd)
				vVisibleArea <= 1'b1;

			if (vFrontPorchEnd)
				vgaVsync <= 1'b0;
			else if (vSyncEnd)
				vgaVsync <= 1'b1;
		end
	end

endmodule

/* hdl/vgaPixelAddress.sv */
`timescale 1ns/1ps

module vgaPixelAddress import vgaTimingPkg::*, vgaBusPkg::*; #(
	parameter int addressBits = 13
) (
	input logic vga_clk,
	input logic rstN,

	input logic hVisibleArea,
	input logic vVisibleArea,
	input logic lineEnd,

	input stretchCount hPixelSize,
	input stretchCount vPixelSize,
	input drawMode mode,

	output logic [addressBits-1:0] vgaAddress,
	output subPixelIndex subPixel
);

	stretchCount hStretch;
	stretchCount vStretch;
	subPixelIndex subPixelCount;
	logic [columnBits-1:0] column;
	logic [rowBits-1:0] row;

	// Linear pixel index, one count per memory word
	logic [addressBits-3:0] pixelIndex;

	logic pixelStep;
	logic wordEnd;
	logic [addressBits-1:0] rawAddress;
	logic [addressBits-1:0] tightAddress;

	assign pixelStep = hVisibleArea && (hStretch == hPixelSize);
	assign wordEnd = pixelStep && (subPixelCount == maxSubPixel);

	// Row and column fields, word aligned
	assign rawAddress = addressBits'({row, column, 2'b00});
	assign tightAddress = {pixelIndex, 2'b00};

	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			hStretch <= '0;
			subPixelCount <= '0;
			column <= '0;
		end else if (hVisibleArea) begin
			if (pixelStep) begin
				hStretch <= '0;
				if (wordEnd) begin
					subPixelCount <= '0;
					column <= column + 1'b1;
				end else begin
					subPixelCount <= subPixelCount + 1'b1;
				end
			end else begin
				hStretch <= hStretch + 1'b1;
			end
		end else begin
			hStretch <= '0;
			subPixelCount <= '0;
			column <= '0;
		end
	end

	// Rows advance at line end, stretched by the vertical pixel size
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			vStretch <= '0;
			row <= '0;
		end else if (!vVisibleArea) begin
			vStretch <= '0;
			row <= '0;
		end else if (lineEnd) begin
			if (vStretch == vPixelSize) begin
				vStretch <= '0;
				row <= row + 1'b1;
			end else begin
				vStretch <= vStretch + 1'b1;
			end
		end
	end

	// Holds through horizontal blanking so lines follow on in memory
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN)
			pixelIndex <= '0;
		else if (!vVisibleArea)
			pixelIndex <= '0;
		else if (wordEnd)
			pixelIndex <= pixelIndex + 1'b1;
	end

	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			vgaAddress <= '0;
			subPixel <= '0;
		end else begin
			subPixel <= subPixelCount;
			case (mode)
				drawTight: vgaAddress <= tightAddress;
				default: vgaAddress <= rawAddress;
			endcase
		end
	end

endmodule

/* hdl/vgaPixelUnpack.sv */
`timescale 1ns/1ps

module vgaPixelUnpack import vgaTimingPkg::*; (
	input logic vga_clk,
	input logic rstN,

	input pixelWord vgaData,
	input subPixelIndex subPixel,

	output colourChannel vgaR,
	output colourChannel vgaG,
	output colourChannel vgaB
);

	colourPixel slot;

	// Top two bits of the word are unused
	always_comb begin
		case (subPixel)
			3'd1: slot = vgaData[11:6];
			3'd2: slot = vgaData[17:12];
			3'd3: slot = vgaData[23:18];
			3'd4: slot = vgaData[29:24];
			default: slot = vgaData[5:0];
		endcase
	end

	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			vgaR <= '0;
			vgaG <= '0;
			vgaB <= '0;
		end else begin
			vgaR <= slot[1:0];
			vgaG <= slot[3:2];
			vgaB <= slot[5:4];
		end
	end

endmodule

/* hdl/vgaController.sv */
`timescale 1ns/1ps

module vgaController import vgaTimingPkg::*, vgaBusPkg::*; #(
	parameter int addressBits = 13
) (
	input logic vga_clk,
	input logic rstN,

	// Configuration bus
	input logic busWe,
	input logic busOe,
	input busAddr busAddress,
	input busWord busDataWrite,
	output busWord busDataRead,
	output logic requestOutput,

	// Frame buffer
	output logic [addressBits-1:0] vgaAddress,
	input pixelWord vgaData,

	output colourChannel vgaR,
	output colourChannel vgaG,
	output colourChannel vgaB,
	output logic vgaHsync,
	output logic vgaVsync
);

	hCount hVisible;
	hCount hFrontPorch;
	hCount hSync;
	hCount hWholeLine;
	vCount vVisible;
	vCount vFrontPorch;
	vCount vSync;
	vCount vWholeLine;
	stretchCount hPixelSize;
	stretchCount vPixelSize;
	drawMode mode;

	logic hVisibleArea;
	logic vVisibleArea;
	logic lineEnd;
	subPixelIndex subPixel;

	vgaConfigRegs configRegs0 (
		.vga_clk(vga_clk), .rstN(rstN),
		.busWe(busWe), .busOe(busOe), .busAddress(busAddress),
		.busDataWrite(busDataWrite), .busDataRead(busDataRead), .requestOutput(requestOutput),
		.hVisible(hVisible), .hFrontPorch(hFrontPorch), .hSync(hSync), .hWholeLine(hWholeLine),
		.vVisible(vVisible), .vFrontPorch(vFrontPorch), .vSync(vSync), .vWholeLine(vWholeLine),
		.hPixelSize(hPixelSize), .vPixelSize(vPixelSize), .mode(mode)
	);

	vgaSyncTiming syncTiming0 (
		.vga_clk(vga_clk), .rstN(rstN),
		.hVisible(hVisible), .hFrontPorch(hFrontPorch), .hSync(hSync), .hWholeLine(hWholeLine),
		.vVisible(vVisible), .vFrontPorch(vFrontPorch), .vSync(vSync), .vWholeLine(vWholeLine),
		.hVisibleArea(hVisibleArea), .vVisibleArea(vVisibleArea), .lineEnd(lineEnd),
		.vgaHsync(vgaHsync), .vgaVsync(vgaVsync)
	);

	vgaPixelAddress #(.addressBits(addressBits)) pixelAddress0 (
		.vga_clk(vga_clk), .rstN(rstN),
		.hVisibleArea(hVisibleArea), .vVisibleArea(vVisibleArea), .lineEnd(lineEnd),
		.hPixelSize(hPixelSize), .vPixelSize(vPixelSize), .mode(mode),
		.vgaAddress(vgaAddress), .subPixel(subPixel)
	);

	// Memory answers combinationally, so colour lags the address by one cycle
	vgaPixelUnpack pixelUnpack0 (
		.vga_clk(vga_clk), .rstN(rstN),
		.vgaData(vgaData), .subPixel(subPixel),
		.vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB)
	);

endmodule

/* test/vgaControllerTb.sv */
`timescale 1ns/1ps

module vgaControllerTb;

	localparam int addressBits = 13;
	localparam int syncTimeout = 20000;
	localparam int setupRows = 27;
	localparam logic [31:0] seed = 32'h62e7_ce42;

	logic vga_clk;
	logic rstN;
	logic busWe;
	logic busOe;
	logic [23:0] busAddress;
	logic [31:0] busDataWrite;
	logic [31:0] busDataRead;
	logic requestOutput;
	logic [addressBits-1:0] vgaAddress;
	logic [31:0] vgaData;
	logic [1:0] vgaR;
	logic [1:0] vgaG;
	logic [1:0] vgaB;
	logic vgaHsync;
	logic vgaVsync;

	int mismatchCount = 0;
	int timeoutCount = 0;

	// Reference model of the scan state and its copy of the registers
	logic [10:0] mH, mIdx, cfgHVis, cfgHFp, cfgHSync, cfgHWhole;
	logic [9:0] mV, cfgVVis, cfgVFp, cfgVSync, cfgVWhole;
	logic [3:0] mHStr, mVStr, mCol, cfgHPix, cfgVPix;
	logic [2:0] mSub, mSubReg;
	logic [6:0] mRow;
	logic [addressBits-1:0] mAddr;
	logic [1:0] mR, mG, mB;
	logic mHVis, mVVis, mHsync, mVsync, cfgTight;

	// Bus stimulus table
	logic opWrite[$];
	logic [23:0] opAddr[$];
	logic [31:0] opData[$];
	logic [31:0] opExpData[$];
	logic opExpReq[$];

	vgaController #(.addressBits(addressBits)) dut0 (
		.vga_clk(vga_clk), .rstN(rstN),
		.busWe(busWe), .busOe(busOe), .busAddress(busAddress),
		.busDataWrite(busDataWrite), .busDataRead(busDataRead), .requestOutput(requestOutput),
		.vgaAddress(vgaAddress), .vgaData(vgaData),
		.vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB), .vgaHsync(vgaHsync), .vgaVsync(vgaVsync)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Frame buffer contents, answered in the same cycle
	function automatic logic [31:0] memoryWord(input logic [addressBits-1:0] addr);
		return xorshift32(seed ^ 32'(addr));
	endfunction

	function automatic logic [5:0] colourSlot(input logic [31:0] word, input logic [2:0] sub);
		int n;
		n = (sub <= 3'd4) ? int'(sub) : 0;
		return 6'(word >> (6 * n));
	endfunction

	assign vgaData = memoryWord(vgaAddress);

	initial begin
		vga_clk = 1'b0;
		forever #4 vga_clk = ~vga_clk;
	end

	task automatic addOp(input logic isWrite, input logic [23:0] addr, input logic [31:0] data,
			input logic [31:0] expData, input logic expReq);
		opWrite.push_back(isWrite);
		opAddr.push_back(addr);
		opData.push_back(data);
		opExpData.push_back(expData);
		opExpReq.push_back(expReq);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic resetModel();
		{mH, mV, mHStr, mVStr, mSub, mSubReg, mCol, mRow, mIdx, mAddr} = '0;
		{mR, mG, mB} = '0;
		{mHVis, mVVis, mHsync, mVsync} = 4'b1111;
		{cfgHVis, cfgHFp, cfgHSync, cfgHWhole} = {11'd799, 11'd839, 11'd967, 11'd1055};
		{cfgVVis, cfgVFp, cfgVSync, cfgVWhole} = {10'd599, 10'd600, 10'd604, 10'd627};
		{cfgHPix, cfgVPix, cfgTight} = {4'd10, 4'd10, 1'b0};
	endtask

	// One clock of the model, every update uses the values from before the edge
	task automatic stepModel();
		logic lineEndNow;
		logic wordEndNow;
		logic [5:0] slotNow;
		lineEndNow = mH == cfgHWhole;
		wordEndNow = mHVis && (mHStr == cfgHPix) && (mSub == 3'd4);
		slotNow = colourSlot(memoryWord(mAddr), mSubReg);
		{mB, mG, mR} = slotNow;
		mSubReg = mSub;
		mAddr = cfgTight ? {mIdx, 2'b00} : {mRow, mCol, 2'b00};
		if (!mHVis) begin
			{mHStr, mSub, mCol} = '0;
		end else if (mHStr != cfgHPix) begin
			mHStr++;
		end else begin
			mHStr = '0;
			mSub = wordEndNow ? 3'd0 : mSub + 3'd1;
			mCol = wordEndNow ? mCol + 4'd1 : mCol;
		end
		if (!mVVis) begin
			{mVStr, mRow, mIdx} = '0;
		end else begin
			if (lineEndNow && mVStr == cfgVPix) begin
				mVStr = '0;
				mRow++;
			end else if (lineEndNow) begin
				mVStr++;
			end
			if (wordEndNow)
				mIdx++;
		end
		if (mH == cfgHVis)
			mHVis = 1'b0;
		else if (lineEndNow)
			mHVis = 1'b1;
		if (mH == cfgHFp)
			mHsync = 1'b0;
		else if (mH == cfgHSync)
			mHsync = 1'b1;
		if (lineEndNow) begin
			if (mV == cfgVVis)
				mVVis = 1'b0;
			else if (mV == cfgVWhole)
				mVVis = 1'b1;
			if (mV == cfgVFp)
				mVsync = 1'b0;
			else if (mV == cfgVSync)
				mVsync = 1'b1;
			mV = (mV == cfgVWhole) ? 10'd0 : mV + 10'd1;
		end
		mH = lineEndNow ? 11'd0 : mH + 11'd1;
		// Register writes land at the same edge
		if (busWe && busAddress[23:12] == 12'h010) begin
			case (busAddress[11:0])
				12'h000: cfgHVis = busDataWrite[10:0];
				12'h004: cfgHFp = busDataWrite[10:0];
				12'h008: cfgHSync = busDataWrite[10:0];
				12'h00C: cfgHWhole = busDataWrite[10:0];
				12'h010: cfgVVis = busDataWrite[9:0];
				12'h014: cfgVFp = busDataWrite[9:0];
				12'h018: cfgVSync = busDataWrite[9:0];
				12'h01C: cfgVWhole = busDataWrite[9:0];
				12'h020: {cfgTight, cfgVPix, cfgHPix} = busDataWrite[8:0];
				default: ;
			endcase
		end
	endtask

	always @(posedge vga_clk) begin
		if (!rstN)
			resetModel();
		else
			stepModel();
	end

	// Scan outputs against the model once reset is released
	always @(negedge vga_clk) begin
		if (rstN) begin
			checkValue("vgaHsync", mHsync, vgaHsync);
			checkValue("vgaVsync", mVsync, vgaVsync);
			checkValue("vgaAddress", mAddr, vgaAddress);
			checkValue("vgaR", mR, vgaR);
			checkValue("vgaG", mG, vgaG);
			checkValue("vgaB", mB, vgaB);
		end
	end

	task automatic applyOp(input int i);
		@(posedge vga_clk);
		#1;
		busWe = opWrite[i];
		busOe = !opWrite[i];
		busAddress = opAddr[i];
		busDataWrite = opData[i];
		@(posedge vga_clk);
		#1;
		busWe = 1'b0;
		busOe = 1'b0;
		@(negedge vga_clk);
		checkValue("requestOutput", opExpReq[i], requestOutput);
		checkValue("busDataRead", opExpData[i], busDataRead);
	endtask

	// Counts cycles until the chosen sync reaches the level
	task automatic waitSync(input logic vertical, input logic level, output int cycles);
		cycles = 0;
		while (((vertical ? vgaVsync : vgaHsync) !== level) && cycles < syncTimeout) begin
			@(negedge vga_clk);
			cycles++;
		end
		if ((vertical ? vgaVsync : vgaHsync) !== level) begin
			timeoutCount++;
			$display("Timeout at %0t: %s did not go to %0b within %0d cycles", $time,
				vertical ? "vgaVsync" : "vgaHsync", level, syncTimeout);
		end
	endtask

	initial begin
		int lowCycles;
		int highCycles;
		resetModel();
		{rstN, busWe, busOe, busAddress, busDataWrite} = '0;
		// Defaults, then unmapped offset and foreign block
		addOp(0, 24'h010000, 0, 32'd799, 1);
		addOp(0, 24'h010004, 0, 32'd839, 1);
		addOp(0, 24'h010008, 0, 32'd967, 1);
		addOp(0, 24'h01000C, 0, 32'd1055, 1);
		addOp(0, 24'h010010, 0, 32'd599, 1);
		addOp(0, 24'h010014, 0, 32'd600, 1);
		addOp(0, 24'h010018, 0, 32'd604, 1);
		addOp(0, 24'h01001C, 0, 32'd627, 1);
		addOp(0, 24'h010020, 0, 32'h0AA, 1);
		addOp(0, 24'h010024, 0, 0, 0);
		addOp(0, 24'h020000, 0, 0, 0);
		// Short frame, upper bits must be dropped
		addOp(1, 24'h010000, 32'hFFFF_F813, 0, 0);
		addOp(1, 24'h010004, 32'h0000_0815, 0, 0);
		addOp(1, 24'h010008, 32'd23, 0, 0);
		addOp(1, 24'h01000C, 32'd27, 0, 0);
		addOp(1, 24'h010010, 32'hFFFF_FC03, 0, 0);
		addOp(1, 24'h010014, 32'd4, 0, 0);
		addOp(1, 24'h010018, 32'd5, 0, 0);
		addOp(1, 24'h01001C, 32'd6, 0, 0);
		addOp(1, 24'h010020, 32'hFFFF_FE10, 0, 0);
		addOp(1, 24'h020000, 32'd5, 0, 0);
		addOp(1, 24'h010024, 32'd9, 0, 0);
		addOp(0, 24'h010000, 0, 32'd19, 1);
		addOp(0, 24'h010004, 0, 32'd21, 1);
		addOp(0, 24'h010010, 0, 32'd3, 1);
		addOp(0, 24'h01001C, 0, 32'd6, 1);
		addOp(0, 24'h010020, 0, 32'h010, 1);
		// Later draw modes, each run for a few frames
		addOp(1, 24'h010020, 32'h001, 0, 0);
		addOp(1, 24'h010020, 32'h100, 0, 0);
		addOp(1, 24'h010020, 32'h111, 0, 0);
		addOp(0, 24'h010020, 0, 32'h111, 1);
		repeat (5) @(posedge vga_clk);
		#1;
		rstN = 1'b1;
		@(negedge vga_clk);
		checkValue("vgaHsync", 1, vgaHsync);
		checkValue("vgaVsync", 1, vgaVsync);
		checkValue("requestOutput", 0, requestOutput);
		for (int i = 0; i < setupRows; i++)
			applyOp(i);
		// Line is 28 clocks, hsync low for 2, vsync low for one line of a 7 line frame
		waitSync(0, 0, lowCycles);
		repeat (3) begin
			waitSync(0, 1, lowCycles);
			waitSync(0, 0, highCycles);
			checkValue("vgaHsync low cycles", 2, lowCycles);
			checkValue("vgaHsync period", 28, lowCycles + highCycles);
		end
		waitSync(1, 0, lowCycles);
		repeat (2) begin
			waitSync(1, 1, lowCycles);
			waitSync(1, 0, highCycles);
			checkValue("vgaVsync low cycles", 28, lowCycles);
			checkValue("vgaVsync period", 196, lowCycles + highCycles);
		end
		for (int i = setupRows; i < opWrite.size(); i++) begin
			applyOp(i);
			repeat (2) begin
				waitSync(1, 0, lowCycles);
				waitSync(1, 1, lowCycles);
			end
		end
		$display("Errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
		if (mismatchCount == 0 && timeoutCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* src.f */
hdl/vgaTimingPkg.sv
hdl/vgaBusPkg.sv
hdl/vgaConfigRegs.sv
hdl/vgaSyncTiming.sv
hdl/vgaPixelAddress.sv
hdl/vgaPixelUnpack.sv
hdl/vgaController.sv
test/vgaControllerTb.sv
